/* verilog.f */
hdl/ex_pkg.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/ex_mem_register.sv
hdl/mispredict_check.sv
hdl/execute_stage.sv
dv/execute_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it.
# the exit status of the simulation binary carries pass or fail.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir \
    && verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module execute_stage_tb -f verilog.f -o execute_stage_sim \
    && ./obj_dir/execute_stage_sim \
    || { echo "simulation did not pass"; exit 1; }

/* dv/execute_stage_tb.sv */
`timescale 1ns/100ps

module execute_stage_tb;

    localparam int n_ops      = 2000;
    localparam int max_cycles = n_ops + 100;  // reset, drain and some slack.

    typedef struct packed {
        logic [ex_pkg::xlen-1:0]       pc;
        logic [ex_pkg::xlen-1:0]       new_pc;
        logic                          br_taken;
        logic [ex_pkg::xlen-1:0]       pc_plus4;
        logic [ex_pkg::xlen-1:0]       alu_result;
        logic [ex_pkg::xlen-1:0]       rs2;
        logic [ex_pkg::dest_w-1:0]     data_dest;
        logic [ex_pkg::lsu_op_w-1:0]   lsu_op;
        logic [ex_pkg::reg_addr_w-1:0] reg_wr_addr;
        logic                          reg_wr_sig;
        logic                          mem_wr_sig;
        logic                          br_pred;
        logic [ex_pkg::xlen-1:0]       new_pc_pred;
    } bundle_t;

    logic clk, reset_n, flush_i;
    logic [ex_pkg::xlen-1:0] pc_i, rs1_i, rs2_i, imm_i, new_pc_pred_i;
    logic [ex_pkg::alu_op_w-1:0] alu_op_i;
    logic src_a_pc_i, src_b_imm_i, br_pred_i, reg_wr_sig_i, mem_wr_sig_i;
    logic [ex_pkg::br_op_w-1:0] br_op_i;
    logic [ex_pkg::lsu_op_w-1:0] lsu_op_i, lsu_op_o;
    logic [ex_pkg::dest_w-1:0] data_dest_i, data_dest_o;
    logic [ex_pkg::reg_addr_w-1:0] reg_wr_addr_i, reg_wr_addr_o;
    logic [ex_pkg::xlen-1:0] pc_o, new_pc_o, pc_plus4_o, alu_result_o, rs2_o;
    logic [ex_pkg::xlen-1:0] new_pc_pred_o, redirect_pc_o;
    logic br_taken_o, reg_wr_sig_o, mem_wr_sig_o, br_pred_o, mispredict_o;

    bundle_t                 exp_d;
    bundle_t                 exp_q;
    logic                    exp_mispredict;
    logic [ex_pkg::xlen-1:0] exp_redirect;
    logic [7*ex_pkg::xlen+14:0] all_outputs;
    logic                    flush_q = 1'b0;
    int cycle_count = 0;
    int flush_recover_seen = 0;
    int pred_right_seen = 0;
    int taken_miss_seen = 0;
    int not_taken_miss_seen = 0;
    int target_miss_seen = 0;

    execute_stage execute_stage_inst (.*);

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31];                     // the negative one is smaller.
        end
        return a < b;
    endfunction

    function automatic logic [31:0] model_alu(input logic [ex_pkg::alu_op_w-1:0] op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ex_pkg::alu_add:    return a + b;
            ex_pkg::alu_sub:    return a - b;
            ex_pkg::alu_and:    return a & b;
            ex_pkg::alu_or:     return a | b;
            ex_pkg::alu_xor:    return a ^ b;
            ex_pkg::alu_sll:    return a << sh;
            ex_pkg::alu_srl:    return a >> sh;
            ex_pkg::alu_sra:    return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
            ex_pkg::alu_slt:    return {31'd0, signed_less(a, b)};
            ex_pkg::alu_sltu:   return {31'd0, a < b};
            ex_pkg::alu_pass_b: return b;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic model_taken(input logic [ex_pkg::br_op_w-1:0] op,
                                         input logic [31:0] a, input logic [31:0] b);
        case (op)
            ex_pkg::br_beq:  return a == b;
            ex_pkg::br_bne:  return a != b;
            ex_pkg::br_blt:  return signed_less(a, b);
            ex_pkg::br_bge:  return !signed_less(a, b);
            ex_pkg::br_bltu: return a < b;
            ex_pkg::br_bgeu: return a >= b;
            ex_pkg::br_jal, ex_pkg::br_jalr: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_target(input logic [ex_pkg::br_op_w-1:0] op,
                                                 input logic [31:0] pc, input logic [31:0] rs1,
                                                 input logic [31:0] imm);
        if (op == ex_pkg::br_jalr) begin
            return (rs1 + imm) & 32'hffff_fffe;
        end
        return pc + imm;
    endfunction

    always_comb begin
        exp_d.pc          = pc_i;
        exp_d.new_pc      = model_target(br_op_i, pc_i, rs1_i, imm_i);
        exp_d.br_taken    = model_taken(br_op_i, rs1_i, rs2_i);
        exp_d.pc_plus4    = pc_i + 32'd4;
        exp_d.alu_result  = model_alu(alu_op_i, src_a_pc_i ? pc_i : rs1_i,
                                      src_b_imm_i ? imm_i : rs2_i);
        exp_d.rs2         = rs2_i;
        exp_d.data_dest   = data_dest_i;
        exp_d.lsu_op      = lsu_op_i;
        exp_d.reg_wr_addr = reg_wr_addr_i;
        exp_d.reg_wr_sig  = reg_wr_sig_i;
        exp_d.mem_wr_sig  = mem_wr_sig_i;
        exp_d.br_pred     = br_pred_i;
        exp_d.new_pc_pred = new_pc_pred_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exp_q <= '0;
        end else if (flush_i) begin
            exp_q <= '0;                      // a flushed slot is an all-zero bubble.
        end else begin
            exp_q <= exp_d;
        end
    end

    assign exp_mispredict = (exp_q.br_pred != exp_q.br_taken)
                            || (exp_q.br_pred && exp_q.br_taken
                                && (exp_q.new_pc != exp_q.new_pc_pred));
    assign exp_redirect = exp_q.br_taken ? exp_q.new_pc : exp_q.pc_plus4;

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error.");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual));
    endtask

    assign all_outputs = {pc_o, new_pc_o, br_taken_o, pc_plus4_o, alu_result_o, rs2_o,
                          data_dest_o, lsu_op_o, reg_wr_addr_o, reg_wr_sig_o, mem_wr_sig_o,
                          br_pred_o, new_pc_pred_o, mispredict_o, redirect_pc_o};

    assert property (@(posedge clk) $rose(reset_n) |-> (all_outputs == '0))
        else abort_run($sformatf("Mismatch all_outputs after reset: expected 0x0, got 0x%h",
                                 $sampled(all_outputs)));

    assert property (@(posedge clk) disable iff (!reset_n) pc_o == exp_q.pc)
        else report_mismatch("pc_o", $sampled(exp_q.pc), $sampled(pc_o));
    assert property (@(posedge clk) disable iff (!reset_n) new_pc_o == exp_q.new_pc)
        else report_mismatch("new_pc_o", $sampled(exp_q.new_pc), $sampled(new_pc_o));
    assert property (@(posedge clk) disable iff (!reset_n) br_taken_o == exp_q.br_taken)
        else report_mismatch("br_taken_o", 32'($sampled(exp_q.br_taken)),
                             32'($sampled(br_taken_o)));
    assert property (@(posedge clk) disable iff (!reset_n) pc_plus4_o == exp_q.pc_plus4)
        else report_mismatch("pc_plus4_o", $sampled(exp_q.pc_plus4), $sampled(pc_plus4_o));
    assert property (@(posedge clk) disable iff (!reset_n) alu_result_o == exp_q.alu_result)
        else report_mismatch("alu_result_o", $sampled(exp_q.alu_result),
                             $sampled(alu_result_o));
    assert property (@(posedge clk) disable iff (!reset_n) rs2_o == exp_q.rs2)
        else report_mismatch("rs2_o", $sampled(exp_q.rs2), $sampled(rs2_o));
    assert property (@(posedge clk) disable iff (!reset_n) data_dest_o == exp_q.data_dest)
        else report_mismatch("data_dest_o", 32'($sampled(exp_q.data_dest)),
                             32'($sampled(data_dest_o)));
    assert property (@(posedge clk) disable iff (!reset_n) lsu_op_o == exp_q.lsu_op)
        else report_mismatch("lsu_op_o", 32'($sampled(exp_q.lsu_op)), 32'($sampled(lsu_op_o)));
    assert property (@(posedge clk) disable iff (!reset_n) reg_wr_addr_o == exp_q.reg_wr_addr)
        else report_mismatch("reg_wr_addr_o", 32'($sampled(exp_q.reg_wr_addr)),
                             32'($sampled(reg_wr_addr_o)));
    assert property (@(posedge clk) disable iff (!reset_n) reg_wr_sig_o == exp_q.reg_wr_sig)
        else report_mismatch("reg_wr_sig_o", 32'($sampled(exp_q.reg_wr_sig)),
                             32'($sampled(reg_wr_sig_o)));
    assert property (@(posedge clk) disable iff (!reset_n) mem_wr_sig_o == exp_q.mem_wr_sig)
        else report_mismatch("mem_wr_sig_o", 32'($sampled(exp_q.mem_wr_sig)),
                             32'($sampled(mem_wr_sig_o)));
    assert property (@(posedge clk) disable iff (!reset_n) br_pred_o == exp_q.br_pred)
        else report_mismatch("br_pred_o", 32'($sampled(exp_q.br_pred)),
                             32'($sampled(br_pred_o)));
    assert property (@(posedge clk) disable iff (!reset_n) new_pc_pred_o == exp_q.new_pc_pred)
        else report_mismatch("new_pc_pred_o", $sampled(exp_q.new_pc_pred),
                             $sampled(new_pc_pred_o));
    assert property (@(posedge clk) disable iff (!reset_n) mispredict_o == exp_mispredict)
        else report_mismatch("mispredict_o", 32'($sampled(exp_mispredict)),
                             32'($sampled(mispredict_o)));
    // the redirect target only means something during a mispredict.
    assert property (@(posedge clk) disable iff (!reset_n)
        mispredict_o |-> redirect_pc_o == exp_redirect)
        else report_mismatch("redirect_pc_o", $sampled(exp_redirect), $sampled(redirect_pc_o));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        flush_q     <= flush_i;
        if (cycle_count >= max_cycles) begin
            abort_run("Timeout: the run did not end within the cycle limit.");
        end else if (reset_n) begin
            if (flush_q && !flush_i) flush_recover_seen <= flush_recover_seen + 1;
            if (exp_q.br_pred && exp_q.br_taken && !exp_mispredict) begin
                pred_right_seen <= pred_right_seen + 1;
            end
            if (!exp_q.br_pred && exp_q.br_taken) taken_miss_seen <= taken_miss_seen + 1;
            if (exp_q.br_pred && !exp_q.br_taken) not_taken_miss_seen <= not_taken_miss_seen + 1;
            if (exp_q.br_pred && exp_q.br_taken && exp_q.new_pc != exp_q.new_pc_pred) begin
                target_miss_seen <= target_miss_seen + 1;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic drive_random_op();
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] imm;
        logic [ex_pkg::br_op_w-1:0] br_op;
        logic [31:0] target;
        logic        taken;
        int          mode;
        pc     = $urandom() & 32'hffff_fffc;
        rs1    = $urandom();
        imm    = $urandom();
        br_op  = 4'($urandom_range(8));
        mode   = $urandom_range(3);
        rs2_i  <= ($urandom_range(3) == 0) ? rs1 : $urandom();  // equal operands for beq.
        taken  = model_taken(br_op, rs1, rs1);
        target = model_target(br_op, pc, rs1, imm);
        pc_i          <= pc;
        rs1_i         <= rs1;
        imm_i         <= imm;
        br_op_i       <= br_op;
        alu_op_i      <= 4'($urandom_range(15));  // unused codes included.
        src_a_pc_i    <= 1'($urandom_range(1));
        src_b_imm_i   <= 1'($urandom_range(1));
        lsu_op_i      <= 3'($urandom());
        data_dest_i   <= 2'($urandom_range(2));
        reg_wr_addr_i <= 5'($urandom());
        reg_wr_sig_i  <= 1'($urandom_range(1));
        mem_wr_sig_i  <= 1'($urandom_range(1));
        flush_i       <= ($urandom_range(15) == 0);
        // the predictor says not taken, the right target, a stale target or the beq guess.
        br_pred_i     <= (mode != 0) && (mode != 3 || taken);
        new_pc_pred_i <= (mode == 0) ? $urandom() : ((mode == 2) ? target ^ 32'h100 : target);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        {pc_i, rs1_i, rs2_i, imm_i, new_pc_pred_i} = '0;
        {alu_op_i, br_op_i, lsu_op_i, data_dest_i, reg_wr_addr_i} = '0;
        {src_a_pc_i, src_b_imm_i, br_pred_i, reg_wr_sig_i, mem_wr_sig_i, flush_i} = '0;
        void'($urandom(32'h1405));
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        repeat (n_ops) begin
            @(posedge clk);
            drive_random_op();
        end
        repeat (2) @(posedge clk);
        if (flush_recover_seen > 0 && pred_right_seen > 0 && taken_miss_seen > 0
                && not_taken_miss_seen > 0 && target_miss_seen > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("The stimulus missed a flush recovery or a prediction case.");
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic                          clk,
    input  logic                          reset_n,

    input  logic [ex_pkg::xlen-1:0]       pc_i,
    input  logic [ex_pkg::xlen-1:0]       rs1_i,
    input  logic [ex_pkg::xlen-1:0]       rs2_i,
    input  logic [ex_pkg::xlen-1:0]       imm_i,
    input  logic [ex_pkg::alu_op_w-1:0]   alu_op_i,
    input  logic                          src_a_pc_i,
    input  logic                          src_b_imm_i,
    input  logic [ex_pkg::br_op_w-1:0]    br_op_i,
    input  logic                          br_pred_i,
    input  logic [ex_pkg::xlen-1:0]       new_pc_pred_i,
    input  logic [ex_pkg::lsu_op_w-1:0]   lsu_op_i,
    input  logic [ex_pkg::dest_w-1:0]     data_dest_i,
    input  logic [ex_pkg::reg_addr_w-1:0] reg_wr_addr_i,
    input  logic                          reg_wr_sig_i,
    input  logic                          mem_wr_sig_i,
    input  logic                          flush_i,

    output logic [ex_pkg::xlen-1:0]       pc_o,
    output logic [ex_pkg::xlen-1:0]       new_pc_o,
    output logic                          br_taken_o,
    output logic [ex_pkg::xlen-1:0]       pc_plus4_o,
    output logic [ex_pkg::xlen-1:0]       alu_result_o,
    output logic [ex_pkg::xlen-1:0]       rs2_o,
    output logic [ex_pkg::dest_w-1:0]     data_dest_o,
    output logic [ex_pkg::lsu_op_w-1:0]   lsu_op_o,
    output logic [ex_pkg::reg_addr_w-1:0] reg_wr_addr_o,
    output logic                          reg_wr_sig_o,
    output logic                          mem_wr_sig_o,
    output logic                          br_pred_o,
    output logic [ex_pkg::xlen-1:0]       new_pc_pred_o,
    output logic                          mispredict_o,
    output logic [ex_pkg::xlen-1:0]       redirect_pc_o
);

    logic [ex_pkg::xlen-1:0] alu_result;
    logic                    br_taken;
    logic [ex_pkg::xlen-1:0] new_pc;
    logic [ex_pkg::xlen-1:0] pc_plus4;

    //////////////////////////////
    // execute
    //////////////////////////////

    alu_unit alu_unit_inst (
        .pc_i         (pc_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .imm_i        (imm_i),
        .alu_op_i     (alu_op_i),
        .src_a_pc_i   (src_a_pc_i),
        .src_b_imm_i  (src_b_imm_i),
        .alu_result_o (alu_result)
    );

    branch_unit branch_unit_inst (
        .pc_i       (pc_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .imm_i      (imm_i),
        .br_op_i    (br_op_i),
        .br_taken_o (br_taken),
        .new_pc_o   (new_pc),
        .pc_plus4_o (pc_plus4)
    );

    //////////////////////////////
    // ex/mem boundary
    //////////////////////////////

    ex_mem_register ex_mem_register_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush_i       (flush_i),
        .pc_i          (pc_i),
        .new_pc_i      (new_pc),
        .br_taken_i    (br_taken),
        .pc_plus4_i    (pc_plus4),
        .alu_result_i  (alu_result),
        .rs2_i         (rs2_i),
        .data_dest_i   (data_dest_i),
        .lsu_op_i      (lsu_op_i),
        .reg_wr_addr_i (reg_wr_addr_i),
        .reg_wr_sig_i  (reg_wr_sig_i),
        .mem_wr_sig_i  (mem_wr_sig_i),
        .br_pred_i     (br_pred_i),
        .new_pc_pred_i (new_pc_pred_i),
        .pc_o          (pc_o),
        .new_pc_o      (new_pc_o),
        .br_taken_o    (br_taken_o),
        .pc_plus4_o    (pc_plus4_o),
        .alu_result_o  (alu_result_o),
        .rs2_o         (rs2_o),
        .data_dest_o   (data_dest_o),
        .lsu_op_o      (lsu_op_o),
        .reg_wr_addr_o (reg_wr_addr_o),
        .reg_wr_sig_o  (reg_wr_sig_o),
        .mem_wr_sig_o  (mem_wr_sig_o),
        .br_pred_o     (br_pred_o),
        .new_pc_pred_o (new_pc_pred_o)
    );

    // checked from the registered bundle so the redirect leaves on a clean edge.
    mispredict_check mispredict_check_inst (
        .br_taken_i    (br_taken_o),
        .br_pred_i     (br_pred_o),
        .new_pc_i      (new_pc_o),
        .new_pc_pred_i (new_pc_pred_o),
        .pc_plus4_i    (pc_plus4_o),
        .mispredict_o  (mispredict_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* hdl/mispredict_check.sv */
`timescale 1ns/100ps

module mispredict_check (
    input  logic                    br_taken_i,
    input  logic                    br_pred_i,
    input  logic [ex_pkg::xlen-1:0] new_pc_i,
    input  logic [ex_pkg::xlen-1:0] new_pc_pred_i,
    input  logic [ex_pkg::xlen-1:0] pc_plus4_i,
    output logic                    mispredict_o,
    output logic [ex_pkg::xlen-1:0] redirect_pc_o
);

    logic dir_miss;
    logic target_miss;

    //////////////////////////////
    // compare with prediction
    //////////////////////////////

    // direction wrong either way.
    assign dir_miss = (br_pred_i != br_taken_i);

    // direction right but the predicted target is stale.
    assign target_miss = br_pred_i && br_taken_i && (new_pc_i != new_pc_pred_i);

    assign mispredict_o = dir_miss || target_miss;

    //////////////////////////////
    // redirect
    //////////////////////////////

    // a wrongly predicted taken branch resumes at the fall-through pc.
    assign redirect_pc_o = br_taken_i ? new_pc_i : pc_plus4_i;

endmodule

/* hdl/ex_mem_register.sv */
`timescale 1ns/100ps

module ex_mem_register (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           flush_i,

    input  logic [ex_pkg::xlen-1:0]        pc_i,
    input  logic [ex_pkg::xlen-1:0]        new_pc_i,
    input  logic                           br_taken_i,
    input  logic [ex_pkg::xlen-1:0]        pc_plus4_i,
    input  logic [ex_pkg::xlen-1:0]        alu_result_i,
    input  logic [ex_pkg::xlen-1:0]        rs2_i,
    input  logic [ex_pkg::dest_w-1:0]      data_dest_i,
    input  logic [ex_pkg::lsu_op_w-1:0]    lsu_op_i,
    input  logic [ex_pkg::reg_addr_w-1:0]  reg_wr_addr_i,
    input  logic                           reg_wr_sig_i,
    input  logic                           mem_wr_sig_i,
    input  logic                           br_pred_i,
    input  logic [ex_pkg::xlen-1:0]        new_pc_pred_i,

    output logic [ex_pkg::xlen-1:0]        pc_o,
    output logic [ex_pkg::xlen-1:0]        new_pc_o,
    output logic                           br_taken_o,
    output logic [ex_pkg::xlen-1:0]        pc_plus4_o,
    output logic [ex_pkg::xlen-1:0]        alu_result_o,
    output logic [ex_pkg::xlen-1:0]        rs2_o,
    output logic [ex_pkg::dest_w-1:0]      data_dest_o,
    output logic [ex_pkg::lsu_op_w-1:0]    lsu_op_o,
    output logic [ex_pkg::reg_addr_w-1:0]  reg_wr_addr_o,
    output logic                           reg_wr_sig_o,
    output logic                           mem_wr_sig_o,
    output logic                           br_pred_o,
    output logic [ex_pkg::xlen-1:0]        new_pc_pred_o
);

    //////////////////////////////
    // pipeline register
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o          <= '0;
            new_pc_o      <= '0;
            br_taken_o    <= 1'b0;
            pc_plus4_o    <= '0;
            alu_result_o  <= '0;
            rs2_o         <= '0;
            data_dest_o   <= '0;
            lsu_op_o      <= '0;
            reg_wr_addr_o <= '0;
            reg_wr_sig_o  <= 1'b0;
            mem_wr_sig_o  <= 1'b0;
            br_pred_o     <= 1'b0;
            new_pc_pred_o <= '0;
        end else if (flush_i) begin
            // the flushed slot becomes a bubble with no side effects.
            pc_o          <= '0;
            new_pc_o      <= '0;
            br_taken_o    <= 1'b0;
            pc_plus4_o    <= '0;
            alu_result_o  <= '0;
            rs2_o         <= '0;
            data_dest_o   <= '0;
            lsu_op_o      <= '0;
            reg_wr_addr_o <= '0;
            reg_wr_sig_o  <= 1'b0;
            mem_wr_sig_o  <= 1'b0;
            br_pred_o     <= 1'b0;
            new_pc_pred_o <= '0;
        end else begin
            pc_o          <= pc_i;
            new_pc_o      <= new_pc_i;
            br_taken_o    <= br_taken_i;
            pc_plus4_o    <= pc_plus4_i;
            alu_result_o  <= alu_result_i;
            rs2_o         <= rs2_i;            // store data for the mem stage.
            data_dest_o   <= data_dest_i;
            lsu_op_o      <= lsu_op_i;
            reg_wr_addr_o <= reg_wr_addr_i;
            reg_wr_sig_o  <= reg_wr_sig_i;
            mem_wr_sig_o  <= mem_wr_sig_i;
            br_pred_o     <= br_pred_i;
            new_pc_pred_o <= new_pc_pred_i;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // a flushed instruction must not write the register file or memory.
    flush_kills_writes: assert property (
        @(posedge clk) disable iff (!reset_n)
        flush_i |=> (!reg_wr_sig_o && !mem_wr_sig_o)
    ) else $error("write enable survived a flush.");

    no_spurious_mem_wr: assert property (
        @(posedge clk) disable iff (!reset_n)
        !mem_wr_sig_i |=> !mem_wr_sig_o
    ) else $error("mem_wr_sig_o raised without a store in ex.");

    no_spurious_reg_wr: assert property (
        @(posedge clk) disable iff (!reset_n)
        !reg_wr_sig_i |=> !reg_wr_sig_o
    ) else $error("reg_wr_sig_o raised without a write in ex.");

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
    input  logic [ex_pkg::xlen-1:0]    pc_i,
    input  logic [ex_pkg::xlen-1:0]    rs1_i,
    input  logic [ex_pkg::xlen-1:0]    rs2_i,
    input  logic [ex_pkg::xlen-1:0]    imm_i,
    input  logic [ex_pkg::br_op_w-1:0] br_op_i,
    output logic                       br_taken_o,
    output logic [ex_pkg::xlen-1:0]    new_pc_o,
    output logic [ex_pkg::xlen-1:0]    pc_plus4_o
);

    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;
    logic                    taken;
    logic [ex_pkg::xlen-1:0] jalr_sum;

    //////////////////////////////
    // condition
    //////////////////////////////

    assign eq   = (rs1_i == rs2_i);
    assign lt_s = ($signed(rs1_i) < $signed(rs2_i));
    assign lt_u = (rs1_i < rs2_i);

    always_comb begin
        case (br_op_i)
            ex_pkg::br_beq: begin
                taken = eq;
            end
            ex_pkg::br_bne: begin
                taken = !eq;
            end
            ex_pkg::br_blt: begin
                taken = lt_s;
            end
            ex_pkg::br_bge: begin
                taken = !lt_s;
            end
            ex_pkg::br_bltu: begin
                taken = lt_u;
            end
            ex_pkg::br_bgeu: begin
                taken = !lt_u;
            end
            ex_pkg::br_jal, ex_pkg::br_jalr: begin
                taken = 1'b1;                    // jumps are unconditional.
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign br_taken_o = taken;

    //////////////////////////////
    // target
    //////////////////////////////

    assign jalr_sum   = rs1_i + imm_i;
    assign new_pc_o   = (br_op_i == ex_pkg::br_jalr) ? {jalr_sum[ex_pkg::xlen-1:1], 1'b0}
                                                     : pc_i + imm_i;
    assign pc_plus4_o = pc_i + 32'd4;            // link value and fall-through pc.

endmodule

/* hdl/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
    input  logic [ex_pkg::xlen-1:0]     pc_i,
    input  logic [ex_pkg::xlen-1:0]     rs1_i,
    input  logic [ex_pkg::xlen-1:0]     rs2_i,
    input  logic [ex_pkg::xlen-1:0]     imm_i,
    input  logic [ex_pkg::alu_op_w-1:0] alu_op_i,
    input  logic                        src_a_pc_i,
    input  logic                        src_b_imm_i,
    output logic [ex_pkg::xlen-1:0]     alu_result_o
);

    logic [ex_pkg::xlen-1:0] op_a;
    logic [ex_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;
    logic                    lt_s;
    logic                    lt_u;

    //////////////////////////////
    // operand select
    //////////////////////////////

    assign op_a  = src_a_pc_i ? pc_i : rs1_i;     // auipc and jal use the pc.
    assign op_b  = src_b_imm_i ? imm_i : rs2_i;
    assign shamt = op_b[4:0];                     // only the low five bits shift.

    assign lt_s = ($signed(op_a) < $signed(op_b));
    assign lt_u = (op_a < op_b);

    //////////////////////////////
    // operation
    //////////////////////////////

    always_comb begin
        case (alu_op_i)
            ex_pkg::alu_add: begin
                alu_result_o = op_a + op_b;
            end
            ex_pkg::alu_sub: begin
                alu_result_o = op_a - op_b;
            end
            ex_pkg::alu_and: begin
                alu_result_o = op_a & op_b;
            end
            ex_pkg::alu_or: begin
                alu_result_o = op_a | op_b;
            end
            ex_pkg::alu_xor: begin
                alu_result_o = op_a ^ op_b;
            end
            ex_pkg::alu_sll: begin
                alu_result_o = op_a << shamt;
            end
            ex_pkg::alu_srl: begin
                alu_result_o = op_a >> shamt;
            end
            ex_pkg::alu_sra: begin
                alu_result_o = $unsigned($signed(op_a) >>> shamt);
            end
            ex_pkg::alu_slt: begin
                alu_result_o = {{(ex_pkg::xlen-1){1'b0}}, lt_s};
            end
            ex_pkg::alu_sltu: begin
                alu_result_o = {{(ex_pkg::xlen-1){1'b0}}, lt_u};
            end
            ex_pkg::alu_pass_b: begin
                alu_result_o = op_b;
            end
            default: begin
                alu_result_o = '0;                // unused codes give zero.
            end
        endcase
    end

endmodule

/* hdl/ex_pkg.sv */
package ex_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int xlen       = 32;  // data and address width.
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 4;
    localparam int br_op_w    = 4;
    localparam int lsu_op_w   = 3;   // opaque to this stage, decoded in mem.
    localparam int dest_w     = 2;

    //////////////////////////////
    // alu operation codes
    //////////////////////////////

    localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
    localparam logic [alu_op_w-1:0] alu_and    = 4'd2;
    localparam logic [alu_op_w-1:0] alu_or     = 4'd3;
    localparam logic [alu_op_w-1:0] alu_xor    = 4'd4;
    localparam logic [alu_op_w-1:0] alu_sll    = 4'd5;
    localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
    localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
    localparam logic [alu_op_w-1:0] alu_slt    = 4'd8;
    localparam logic [alu_op_w-1:0] alu_sltu   = 4'd9;
    localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;  // lui result is the immediate.

    //////////////////////////////
    // branch codes
    //////////////////////////////

    localparam logic [br_op_w-1:0] br_none = 4'd0;
    localparam logic [br_op_w-1:0] br_beq  = 4'd1;
    localparam logic [br_op_w-1:0] br_bne  = 4'd2;
    localparam logic [br_op_w-1:0] br_blt  = 4'd3;
    localparam logic [br_op_w-1:0] br_bge  = 4'd4;
    localparam logic [br_op_w-1:0] br_bltu = 4'd5;
    localparam logic [br_op_w-1:0] br_bgeu = 4'd6;
    localparam logic [br_op_w-1:0] br_jal  = 4'd7;
    localparam logic [br_op_w-1:0] br_jalr = 4'd8;

    //////////////////////////////
    // writeback destination
    //////////////////////////////

    localparam logic [dest_w-1:0] dest_alu = 2'd0;
    localparam logic [dest_w-1:0] dest_mem = 2'd1;
    localparam logic [dest_w-1:0] dest_pc4 = 2'd2;  // link address for jal and jalr.

endpackage
